// File: Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
TOP        = tb_dc_mem_control
FILELIST   = sources.f
BUILD      = obj_dir
LOG        = sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)

# The run passes only if the log holds the pass message
sim: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^Everything OK$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: cmd_fifo.sv
`timescale 1ns/1ps

module cmd_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = 4
) (
  input  logic clk,
  input  logic reset,
  input  logic push,
  input  T     din,
  output logic full,
  input  logic pop,
  output T     dout,
  output logic empty
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  T              mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          do_push;
  logic          do_pop;

  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
    return (p == PW'(DEPTH - 1)) ? '0 : p + PW'(1);
  endfunction

  assign full    = (count == CW'(DEPTH));
  assign empty   = (count == '0);
  assign dout    = mem[rd_ptr];
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop) rd_ptr <= next_ptr(rd_ptr);
      if (do_push && !do_pop) count <= count + CW'(1);
      else if (do_pop && !do_push) count <= count - CW'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= din;
  end

  // The decoder and the port both look at the flags before they act
  no_push_when_full: assert property (@(posedge clk) disable iff (reset) !(push && full))
    else $error("push into a full FIFO");
  no_pop_when_empty: assert property (@(posedge clk) disable iff (reset) !(pop && empty))
    else $error("pop from an empty FIFO");

endmodule

// File: dc_config.svh
`ifndef DC_CONFIG_SVH
`define DC_CONFIG_SVH

// Memory address width, 256 words of external memory
`define DC_ADDR_WIDTH 8

// Data word width, also the width of the top of stack
`define DC_WORD_WIDTH 16

// Number of data counters DC0 to DC3
`define DC_COUNT 4

// Entries in the memory command FIFO
`define DC_FIFO_DEPTH 4

// Instruction opcodes
`define DC_OP_READ  2'd0
`define DC_OP_WRITE 2'd1
`define DC_OP_SETF  2'd2
`define DC_OP_SETB  2'd3

`endif

// File: dc_decoder.sv
`timescale 1ns/1ps
`include "dc_config.svh"

module dc_decoder (
  input  logic              clk,
  input  logic              reset,
  input  logic              in_req,
  input  dc_pkg::dc_instr_t in_instr,
  output logic              in_ack,
  output dc_pkg::word_t     in_result,
  output logic              cmd_push,
  output dc_pkg::mem_cmd_t  cmd,
  input  logic              cmd_full,
  input  dc_pkg::dc_fill_t  fill
);
  import dc_pkg::*;

  // Per-counter state
  addr_t                addr_q [`DC_COUNT];
  word_t                word_q [`DC_COUNT];
  logic [`DC_COUNT-1:0] back_q;
  logic [`DC_COUNT-1:0] loaded_q;
  logic [`DC_COUNT-1:0] pending_q;
  // Set when the address moved while a refill was still in flight
  logic [`DC_COUNT-1:0] stale_q;

  logic    req_q;
  logic    accept;
  logic    reload_any;
  logic    reload_go;
  dc_sel_t reload_sel;
  dc_sel_t sel;
  addr_t   cur_addr;
  addr_t   step_addr;
  addr_t   wr_addr;
  logic    fill_hit;

  assign sel      = in_instr.sel;
  assign cur_addr = addr_q[sel];
  assign fill_hit = fill.valid && (fill.sel == sel);

  // The request is registered first, so the instruction executes in the cycle after
  // in_req is sampled and in_ack rises at the edge that ends that cycle
  assign accept = req_q && !in_ack && !cmd_full &&
                  ((in_instr.op != OP_READ) || loaded_q[sel]);

  // Reloader picks the lowest unloaded counter with no read in flight
  always_comb begin
    reload_any = 1'b0;
    reload_sel = '0;
    for (int i = `DC_COUNT - 1; i >= 0; i--) begin
      if (!loaded_q[i] && !pending_q[i]) begin
        reload_any = 1'b1;
        reload_sel = dc_sel_t'(i);
      end
    end
  end

  assign reload_go = !accept && !cmd_full && reload_any;

  // Forward counters post-increment, backward counters pre-decrement on a write
  always_comb begin
    step_addr = cur_addr + addr_t'(1);
    wr_addr   = cur_addr;
    if ((in_instr.op == OP_WRITE) && back_q[sel]) begin
      step_addr = cur_addr - addr_t'(1);
      wr_addr   = step_addr;
    end
  end

  always_comb begin
    cmd      = '0;
    cmd_push = 1'b0;
    if (accept) begin
      cmd.sel = sel;
      case (in_instr.op)
        OP_READ: begin
          // Refill at the advanced address
          cmd_push = 1'b1;
          cmd.addr = step_addr;
        end
        OP_WRITE: begin
          cmd_push   = 1'b1;
          cmd.write  = 1'b1;
          cmd.addr   = wr_addr;
          cmd.data   = in_instr.operand;
        end
        default: cmd_push = 1'b0;
      endcase
    end else if (reload_go) begin
      cmd_push = 1'b1;
      cmd.sel  = reload_sel;
      cmd.addr = addr_q[reload_sel];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      req_q     <= 1'b0;
      in_ack    <= 1'b0;
      back_q    <= '0;
      loaded_q  <= '0;
      pending_q <= '0;
      stale_q   <= '0;
      for (int i = 0; i < `DC_COUNT; i++) begin
        addr_q[i] <= '0;
      end
    end else begin
      req_q <= in_req;
      if (in_ack && !req_q) begin
        in_ack <= 1'b0;
      end
      // A stale fill only clears the pending read so the reloader asks again
      if (fill.valid) begin
        pending_q[fill.sel] <= 1'b0;
        stale_q[fill.sel]   <= 1'b0;
        loaded_q[fill.sel]  <= !stale_q[fill.sel];
      end
      if (reload_go) begin
        pending_q[reload_sel] <= 1'b1;
      end
      if (accept) begin
        in_ack        <= 1'b1;
        loaded_q[sel] <= 1'b0;
        case (in_instr.op)
          OP_READ: begin
            addr_q[sel]    <= step_addr;
            pending_q[sel] <= 1'b1;
          end
          OP_WRITE: addr_q[sel] <= step_addr;
          default: begin
            addr_q[sel] <= addr_t'(in_instr.operand);
            back_q[sel] <= (in_instr.op == OP_SETB);
          end
        endcase
        if ((in_instr.op != OP_READ) && pending_q[sel] && !fill_hit) begin
          stale_q[sel] <= 1'b1;
        end
      end
    end
  end

  // Cached words and the returned result
  always_ff @(posedge clk) begin
    if (fill.valid && !stale_q[fill.sel]) begin
      word_q[fill.sel] <= fill.data;
    end
    if (accept) begin
      in_result <= (in_instr.op == OP_READ) ? word_q[sel] : '0;
    end
  end

  // The acknowledge is held for as long as the processor keeps its request up
  ack_held_while_req: assert property (
    @(posedge clk) disable iff (reset) in_ack && in_req |=> in_ack
  ) else $error("in_ack dropped while in_req was still high");

endmodule

// File: dc_mem_control.sv
`timescale 1ns/1ps
`include "dc_config.svh"

module dc_mem_control (
  input  logic              clk,
  input  logic              reset,
  input  logic              in_req,
  input  dc_pkg::dc_instr_t in_instr,
  output logic              in_ack,
  output dc_pkg::word_t     in_result,
  output logic              mem_req,
  output dc_pkg::mem_cmd_t  mem_cmd,
  input  logic              mem_ack,
  input  dc_pkg::word_t     mem_rdata
);
  import dc_pkg::*;

  logic     cmd_push;
  logic     cmd_full;
  logic     cmd_pop;
  logic     cmd_empty;
  mem_cmd_t cmd_in;
  mem_cmd_t cmd_head;
  dc_fill_t fill;

  dc_decoder u_decoder (
    .clk       (clk),
    .reset     (reset),
    .in_req    (in_req),
    .in_instr  (in_instr),
    .in_ack    (in_ack),
    .in_result (in_result),
    .cmd_push  (cmd_push),
    .cmd       (cmd_in),
    .cmd_full  (cmd_full),
    .fill      (fill)
  );

  cmd_fifo #(.T(mem_cmd_t), .DEPTH(`DC_FIFO_DEPTH)) u_fifo (
    .clk   (clk),
    .reset (reset),
    .push  (cmd_push),
    .din   (cmd_in),
    .full  (cmd_full),
    .pop   (cmd_pop),
    .dout  (cmd_head),
    .empty (cmd_empty)
  );

  mem_port u_port (
    .clk       (clk),
    .reset     (reset),
    .empty     (cmd_empty),
    .head      (cmd_head),
    .pop       (cmd_pop),
    .mem_req   (mem_req),
    .mem_cmd   (mem_cmd),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .fill      (fill)
  );

endmodule

// File: dc_pkg.sv
`include "dc_config.svh"

package dc_pkg;

  typedef logic [`DC_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`DC_WORD_WIDTH-1:0] word_t;
  typedef logic [1:0]                dc_sel_t;

  typedef enum logic [1:0] {
    OP_READ  = `DC_OP_READ,
    OP_WRITE = `DC_OP_WRITE,
    OP_SETF  = `DC_OP_SETF,
    OP_SETB  = `DC_OP_SETB
  } dc_op_e;

  // One instruction from the stack processor, operand is the top of stack
  typedef struct packed {
    dc_op_e  op;
    dc_sel_t sel;
    word_t   operand;
  } dc_instr_t;

  // Memory command, sel tells which counter a read refills
  typedef struct packed {
    logic    write;
    dc_sel_t sel;
    addr_t   addr;
    word_t   data;
  } mem_cmd_t;

  // Read data returned from the memory port for one cycle
  typedef struct packed {
    logic    valid;
    dc_sel_t sel;
    word_t   data;
  } dc_fill_t;

endpackage

// File: mem_port.sv
`timescale 1ns/1ps

module mem_port (
  input  logic             clk,
  input  logic             reset,
  input  logic             empty,
  input  dc_pkg::mem_cmd_t head,
  output logic             pop,
  output logic             mem_req,
  output dc_pkg::mem_cmd_t mem_cmd,
  input  logic             mem_ack,
  input  dc_pkg::word_t    mem_rdata,
  output dc_pkg::dc_fill_t fill
);
  import dc_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_RELEASE,
    S_DONE
  } state_e;

  state_e   state_q;
  dc_fill_t fill_q;

  // A command is taken from the FIFO head only when the port is idle
  assign pop     = (state_q == S_IDLE) && !empty;
  assign mem_req = (state_q == S_REQ);
  assign fill    = fill_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= S_IDLE;
      fill_q  <= '0;
    end else begin
      fill_q.valid <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (!empty) state_q <= S_REQ;
        end
        S_REQ: begin
          if (mem_ack) begin
            // Read data is only valid while the acknowledge is up
            fill_q.valid <= !mem_cmd.write;
            fill_q.sel   <= mem_cmd.sel;
            fill_q.data  <= mem_rdata;
            state_q      <= S_RELEASE;
          end
        end
        S_RELEASE: begin
          if (!mem_ack) state_q <= S_DONE;
        end
        // One spare cycle between transfers
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pop) mem_cmd <= head;
  end

  // Four-phase rule on the memory side
  req_held_until_ack: assert property (
    @(posedge clk) disable iff (reset) mem_req && !mem_ack |=> mem_req
  ) else $error("mem_req dropped before mem_ack");

endmodule

// File: sources.f
+incdir+.
dc_pkg.sv
cmd_fifo.sv
mem_port.sv
dc_decoder.sv
dc_mem_control.sv
tb_dc_mem_control.sv

// File: tb_dc_mem_control.sv
`timescale 1ns/1ps
`include "dc_config.svh"

module tb_dc_mem_control;
  import dc_pkg::*;

  localparam int MEM_WORDS = 1 << `DC_ADDR_WIDTH;
  // Roughly 60 instructions and reloads at 10 cycles each in the worst case, with a wide margin
  localparam int TIMEOUT_CYCLES = 5000;

  logic      clk;
  logic      reset;
  logic      in_req;
  dc_instr_t in_instr;
  logic      in_ack;
  word_t     in_result;
  logic      mem_req;
  mem_cmd_t  mem_cmd;
  logic      mem_ack;
  word_t     mem_rdata;

  word_t    mem_model [MEM_WORDS];
  // Expected memory contents that the tests keep up to date from the counter rules
  word_t    ref_mem [MEM_WORDS];
  mem_cmd_t cmd_log [$];
  logic     slow_mem;
  int       req_drops;
  int       errors;
  int       tests_run;
  int       tests_failed;
  int       cycles;

  dc_mem_control dut (
    .clk       (clk),
    .reset     (reset),
    .in_req    (in_req),
    .in_instr  (in_instr),
    .in_ack    (in_ack),
    .in_result (in_result),
    .mem_req   (mem_req),
    .mem_cmd   (mem_cmd),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles because a handshake never completed", cycles);
      $display("Something failed");
      $finish;
    end
  end

  // The external memory answers each request after 1 to 3 cycles, or after 3 when slow
  initial begin
    int lat;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    void'($urandom(10941));
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem_model[a] = word_t'($urandom);
      ref_mem[a]   = mem_model[a];
    end
    forever begin
      @(negedge clk);
      if (!reset && mem_req) begin
        lat = slow_mem ? 3 : 1 + int'($urandom % 3);
        repeat (lat) begin
          @(negedge clk);
          assert (mem_req) else begin
            $display("mem_req fell while the memory had not acknowledged yet");
            req_drops++;
          end
        end
        cmd_log.push_back(mem_cmd);
        if (mem_cmd.write) begin
          mem_model[mem_cmd.addr] = mem_cmd.data;
        end else begin
          mem_rdata = mem_model[mem_cmd.addr];
        end
        mem_ack = 1'b1;
        while (mem_req) @(negedge clk);
        mem_ack   = 1'b0;
        mem_rdata = '0;
      end
    end
  end

  task automatic check_value(input string test_name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    assert (actual == expected) else begin
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
      errors++;
    end
  endtask

  // One four-phase exchange on the instruction input
  task automatic run_instr(input string test_name, input dc_op_e kind, input dc_sel_t dc,
                           input word_t value, output word_t result);
    @(negedge clk);
    in_instr = '{op: kind, sel: dc, operand: value};
    in_req   = 1'b1;
    @(negedge clk);
    while (!in_ack) @(negedge clk);
    result = in_result;
    in_req = 1'b0;
    while (in_ack) @(negedge clk);
    if (kind != OP_READ) begin
      check_value(test_name, "result of a non-read", 32'(0), 32'(result));
    end
  endtask

  task automatic read_expect(input string test_name, input dc_sel_t dc, input word_t expected);
    word_t result;
    run_instr(test_name, OP_READ, dc, '0, result);
    check_value(test_name, $sformatf("read on DC%0d", dc), 32'(expected), 32'(result));
  endtask

  task automatic finish_test(input string name, input int start_errors);
    tests_run++;
    if (errors == start_errors) begin
      $display("Test %s passed", name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", name, errors - start_errors);
    end
  endtask

  task automatic test_reset_reloads();
    int start_errors;
    start_errors = errors;
    while (cmd_log.size() < 4) @(negedge clk);
    for (int i = 0; i < 4; i++) begin
      check_value("reset_reloads", $sformatf("command %0d", i),
                  32'({1'b0, dc_sel_t'(i), addr_t'(0)}),
                  32'({cmd_log[i].write, cmd_log[i].sel, cmd_log[i].addr}));
    end
    finish_test("reset_reloads", start_errors);
  endtask

  task automatic test_forward_reads();
    int    start_errors;
    addr_t base;
    word_t result;
    start_errors = errors;
    // Starts near the top so that the counter wraps to address 0
    base = 8'hFD;
    run_instr("forward_reads", OP_SETF, 2'd0, word_t'(base), result);
    for (int i = 0; i < 5; i++) begin
      read_expect("forward_reads", 2'd0, ref_mem[addr_t'(base + i)]);
    end
    finish_test("forward_reads", start_errors);
  endtask

  task automatic test_write_read_back();
    int    start_errors;
    addr_t base;
    word_t result;
    start_errors = errors;
    base = 8'h40;
    run_instr("write_read_back", OP_SETF, 2'd0, word_t'(base), result);
    ref_mem[base] = 16'hBEEF;
    run_instr("write_read_back", OP_WRITE, 2'd0, 16'hBEEF, result);
    run_instr("write_read_back", OP_SETF, 2'd0, word_t'(base), result);
    read_expect("write_read_back", 2'd0, 16'hBEEF);
    check_value("write_read_back", "memory word", 32'(16'hBEEF), 32'(mem_model[base]));
    finish_test("write_read_back", start_errors);
  endtask

  task automatic test_backward_writes();
    int    start_errors;
    addr_t base;
    word_t result;
    start_errors = errors;
    base = 8'h20;
    run_instr("backward_writes", OP_SETB, 2'd1, word_t'(base), result);
    // Pre-decrement puts the first write one below the set address
    ref_mem[addr_t'(base - 1)] = 16'h1111;
    run_instr("backward_writes", OP_WRITE, 2'd1, 16'h1111, result);
    ref_mem[addr_t'(base - 2)] = 16'h2222;
    run_instr("backward_writes", OP_WRITE, 2'd1, 16'h2222, result);
    run_instr("backward_writes", OP_SETF, 2'd1, word_t'(addr_t'(base - 2)), result);
    read_expect("backward_writes", 2'd1, 16'h2222);
    read_expect("backward_writes", 2'd1, 16'h1111);
    finish_test("backward_writes", start_errors);
  endtask

  function automatic int count_writes(input int first);
    int n;
    n = 0;
    for (int j = first; j < cmd_log.size(); j++) begin
      if (cmd_log[j].write) n++;
    end
    return n;
  endfunction

  task automatic test_slow_write_burst();
    int    start_errors;
    int    first;
    int    seen;
    addr_t base;
    word_t value;
    word_t result;
    start_errors = errors;
    base     = 8'h80;
    slow_mem = 1'b1;
    run_instr("slow_write_burst", OP_SETF, 2'd2, word_t'(base), result);
    first = cmd_log.size();
    for (int i = 0; i < 8; i++) begin
      value = word_t'(16'hC000 + i * 16'h0111);
      ref_mem[addr_t'(base + i)] = value;
      run_instr("slow_write_burst", OP_WRITE, 2'd2, value, result);
    end
    while (count_writes(first) < 8) @(negedge clk);
    // Refill reads of DC2 sit between the writes and are skipped
    seen = 0;
    for (int j = first; j < cmd_log.size(); j++) begin
      if (cmd_log[j].write) begin
        check_value("slow_write_burst", $sformatf("address of write %0d", seen),
                    32'(addr_t'(base + seen)), 32'(cmd_log[j].addr));
        check_value("slow_write_burst", $sformatf("data of write %0d", seen),
                    32'(ref_mem[addr_t'(base + seen)]), 32'(cmd_log[j].data));
        seen++;
      end
    end
    assert (req_drops == 0) else begin
      $display("mem_req fell before mem_ack rose in %0d transfers", req_drops);
      errors++;
    end
    slow_mem = 1'b0;
    finish_test("slow_write_burst", start_errors);
  endtask

  task automatic test_alternate_counters();
    int    start_errors;
    addr_t base_a;
    addr_t base_b;
    word_t result;
    start_errors = errors;
    base_a = 8'h10;
    base_b = 8'hF0;
    run_instr("alternate_counters", OP_SETF, 2'd1, word_t'(base_a), result);
    run_instr("alternate_counters", OP_SETF, 2'd3, word_t'(base_b), result);
    for (int i = 0; i < 4; i++) begin
      read_expect("alternate_counters", 2'd1, ref_mem[addr_t'(base_a + i)]);
      read_expect("alternate_counters", 2'd3, ref_mem[addr_t'(base_b + i)]);
    end
    finish_test("alternate_counters", start_errors);
  endtask

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    in_req       = 1'b0;
    in_instr     = '0;
    slow_mem     = 1'b0;
    req_drops    = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    cycles       = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_reset_reloads();
    test_forward_reads();
    test_write_read_back();
    test_backward_writes();
    test_slow_write_burst();
    test_alternate_counters();
    $display("Tests run %0d, passed %0d, failed %0d, failed checks %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
